// ==== list.f ====
rtl/hint_pkg.sv
rtl/hint_decode_ctrl.sv
rtl/hint_decode.sv
rtl/credit_fifo.sv
rtl/hint_mem.sv
rtl/hint_decode_top.sv
testbench/hint_decode_chk.sv
testbench/tb_hint_decode.sv

// ==== rtl/credit_fifo.sv ====
`timescale 1ns/1ps
// No full flag; the writer must obey the credit rule or entries are overwritten

module credit_fifo (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic               wr_valid_i,
    input  hint_pkg::hint_wr_t wr_req_i,
    input  logic               pop_i,
    output logic               rd_valid_o,
    output hint_pkg::hint_wr_t rd_req_o,
    output logic               credit_ret_o
);
    import hint_pkg::*;

    hint_wr_t                         entries [WR_FIFO_DEPTH];
    logic [$clog2(WR_FIFO_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(WR_FIFO_DEPTH)-1:0] rd_ptr_q;
    logic [CREDIT_W-1:0]              fill_q;
    logic                             do_pop;

    // Head is visible whenever anything is stored
    assign rd_valid_o = fill_q != '0;
    assign rd_req_o   = entries[rd_ptr_q];

    // A pop frees one slot and hands its credit straight back
    assign do_pop       = pop_i && rd_valid_o;
    assign credit_ret_o = do_pop;

    // ----------------------------------------
    // Pointers and fill level
    // ----------------------------------------

    // Depth is a power of two, so pointers wrap on their own
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else if (zeroize_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (wr_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            fill_q <= fill_q + CREDIT_W'(wr_valid_i) - CREDIT_W'(do_pop);
        end
    end

    // Entry storage, wiped on zeroize so no hint data lingers
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            for (int i = 0; i < WR_FIFO_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_valid_i) begin
            entries[wr_ptr_q] <= wr_req_i;
        end
    end

endmodule

// ==== rtl/hint_decode.sv ====
`timescale 1ns/1ps
// Field must stay stable from start_i to done_o; error_o is valid at done_o until the next start

module hint_decode (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  logic                            start_i,
    input  hint_pkg::hint_sig_t             encoded_h_i,
    input  logic [hint_pkg::MEM_ADDR_W-1:0] base_addr_i,
    input  logic                            credit_ret_i,
    output logic                            wr_valid_o,
    output hint_pkg::hint_wr_t              wr_req_o,
    output logic                            done_o,
    output logic                            busy_o,
    output logic                            error_o
);
    import hint_pkg::*;

    logic [3:0]            poly_idx;
    logic [6:0]            rd_ptr;
    logic [3:0]            lane_map;
    logic [3:0]            lane_q;
    logic                  clear_bitmap;
    logic [5:0]            word_sel;
    logic                  issue;
    logic [MEM_ADDR_W-1:0] issue_addr;
    logic [7:0]            count_q;
    logic [7:0]            prev_q;
    logic [7:0]            poly_hints;
    logic [3:0][7:0]       fetch;
    logic [3:0][7:0]       hint_q;
    logic [7:0]            last_q;
    logic                  seen_q;
    logic [HINT_N-1:0]     bitmap_q;
    logic                  count_err;
    logic                  order_err;
    logic                  tail_err;

    hint_decode_ctrl u_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .start_i       (start_i),
        .base_addr_i   (base_addr_i),
        .poly_hints_i  (poly_hints),
        .index_error_i (error_o),
        .credit_ret_i  (credit_ret_i),
        .poly_idx_o    (poly_idx),
        .rd_ptr_o      (rd_ptr),
        .lane_map_o    (lane_map),
        .clear_bitmap_o(clear_bitmap),
        .word_sel_o    (word_sel),
        .wr_valid_o    (issue),
        .wr_addr_o     (issue_addr),
        .done_o        (done_o),
        .busy_o        (busy_o)
    );

    // Hints of this polynomial are the step from the previous cumulative count
    assign poly_hints = count_q - prev_q;

    // ----------------------------------------
    // Field checks
    // ----------------------------------------

    assign count_err = (count_q < prev_q) || (count_q > 8'(HINT_OMEGA));

    // Live lanes form a prefix, so each lane only needs its left neighbour
    // The first hint of a polynomial has no predecessor, which lets index 0 through
    always_comb begin
        order_err = lane_q[0] && seen_q && (hint_q[0] <= last_q);
        for (int l = 1; l < 4; l++) begin
            if (lane_q[l] && (hint_q[l] <= hint_q[l-1])) begin
                order_err = 1'b1;
            end
        end
    end

    // Index bytes past the final cumulative count must all be zero
    always_comb begin
        tail_err = 1'b0;
        for (int i = 0; i < HINT_OMEGA; i++) begin
            if ((8'(i) >= encoded_h_i[HINT_OMEGA+HINT_K-1]) && (encoded_h_i[i] != '0)) begin
                tail_err = 1'b1;
            end
        end
    end

    // Reads that run past the index region return zero and are never live
    always_comb begin
        for (int l = 0; l < 4; l++) begin
            if (({1'b0, rd_ptr} + 8'(l)) < 8'(HINT_OMEGA)) begin
                fetch[l] = encoded_h_i[{1'b0, rd_ptr} + 8'(l)];
            end else begin
                fetch[l] = '0;
            end
        end
    end

    // ----------------------------------------
    // Control registers
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count_q    <= '0;
            prev_q     <= '0;
            lane_q     <= '0;
            seen_q     <= 1'b0;
            last_q     <= '0;
            wr_valid_o <= 1'b0;
            error_o    <= 1'b0;
        end else if (zeroize_i) begin
            count_q    <= '0;
            prev_q     <= '0;
            lane_q     <= '0;
            seen_q     <= 1'b0;
            last_q     <= '0;
            wr_valid_o <= 1'b0;
            error_o    <= 1'b0;
        end else begin
            // Write word follows its select by one cycle
            wr_valid_o <= issue;
            lane_q     <= lane_map;
            if (start_i && !busy_o) begin
                count_q <= '0;
                prev_q  <= '0;
                error_o <= 1'b0;
            end else begin
                if (clear_bitmap) begin
                    prev_q  <= count_q;
                    count_q <= encoded_h_i[HINT_OMEGA+poly_idx];
                end
                // Sticky verdict, settled well before the last word is selected
                if (busy_o) begin
                    error_o <= error_o | count_err | order_err | tail_err;
                end
            end
            // Last index of a full group is the predecessor for the next group
            if (clear_bitmap) begin
                seen_q <= 1'b0;
            end else if (lane_q[3]) begin
                seen_q <= 1'b1;
                last_q <= hint_q[3];
            end
        end
    end

    // ----------------------------------------
    // Index bytes, bitmap and write word
    // ----------------------------------------

    always_ff @(posedge clk) begin
        hint_q <= fetch;
        if (zeroize_i || clear_bitmap) begin
            bitmap_q <= '0;
        end else begin
            for (int l = 0; l < 4; l++) begin
                if (lane_q[l]) begin
                    bitmap_q[hint_q[l]] <= 1'b1;
                end
            end
        end
        // Each bitmap bit is zero-extended into its own coefficient lane
        if (zeroize_i) begin
            wr_req_o <= '0;
        end else if (issue) begin
            wr_req_o.addr <= issue_addr;
            for (int l = 0; l < COEFFS_PER_WORD; l++) begin
                wr_req_o.data[l] <= COEFF_W'(bitmap_q[{word_sel, 2'(l)}]);
            end
        end
    end

endmodule

// ==== rtl/hint_decode_ctrl.sv ====
`timescale 1ns/1ps
// Walk length is fixed per polynomial; writes wait for credits and no write is ever dropped

module hint_decode_ctrl (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  logic                            start_i,
    input  logic [hint_pkg::MEM_ADDR_W-1:0] base_addr_i,
    input  logic [7:0]                      poly_hints_i,
    input  logic                            index_error_i,
    input  logic                            credit_ret_i,
    output logic [3:0]                      poly_idx_o,
    output logic [6:0]                      rd_ptr_o,
    output logic [3:0]                      lane_map_o,
    output logic                            clear_bitmap_o,
    output logic [5:0]                      word_sel_o,
    output logic                            wr_valid_o,
    output logic [hint_pkg::MEM_ADDR_W-1:0] wr_addr_o,
    output logic                            done_o,
    output logic                            busy_o
);
    import hint_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_READ,
        ST_SETTLE,
        ST_WALK,
        ST_DONE
    } state_t;

    state_t              state_q;
    logic [4:0]          grp_q;
    logic [6:0]          base_ptr_q;
    logic [CREDIT_W-1:0] credit_q;
    logic                have_credit;
    logic                last_group;
    logic                last_word;

    // A credit returning in this cycle may be spent at once
    assign have_credit = (credit_q != '0) || credit_ret_i;
    assign wr_valid_o  = (state_q == ST_WALK) && have_credit;

    // Enough groups of four to cover every index byte, whatever the count
    assign last_group = grp_q == 5'((HINT_OMEGA + 3) / 4 - 1);
    assign last_word  = word_sel_o == 6'(WORDS_PER_POLY - 1);

    assign clear_bitmap_o = state_q == ST_LOAD;
    assign done_o         = state_q == ST_DONE;
    assign busy_o         = state_q != ST_IDLE;

    // Index reads start at the running count of earlier polynomials
    assign rd_ptr_o  = base_ptr_q + {grp_q, 2'b00};
    assign wr_addr_o = base_addr_i + MEM_ADDR_W'(poly_idx_o * WORDS_PER_POLY + word_sel_o);

    // A lane is live while its offset is below the hint count of this polynomial
    // Once the field is known to be malformed no further bits are marked
    always_comb begin
        for (int l = 0; l < 4; l++) begin
            lane_map_o[l] = (state_q == ST_READ) && !index_error_i &&
                            (({1'b0, grp_q, 2'b00} + 8'(l)) < poly_hints_i);
        end
    end

    // ----------------------------------------
    // Sequencer and credit counter
    // ----------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= ST_IDLE;
            poly_idx_o <= '0;
            grp_q      <= '0;
            word_sel_o <= '0;
            base_ptr_q <= '0;
            credit_q   <= CREDIT_W'(WR_FIFO_DEPTH);
        end else if (zeroize_i) begin
            // The buffer is emptied too, so all credits come back
            state_q    <= ST_IDLE;
            poly_idx_o <= '0;
            grp_q      <= '0;
            word_sel_o <= '0;
            base_ptr_q <= '0;
            credit_q   <= CREDIT_W'(WR_FIFO_DEPTH);
        end else begin
            credit_q <= credit_q - CREDIT_W'(wr_valid_o) + CREDIT_W'(credit_ret_i);
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q    <= ST_LOAD;
                        poly_idx_o <= '0;
                        base_ptr_q <= '0;
                    end
                end
                ST_LOAD: begin
                    // Datapath latches the count of this polynomial here
                    state_q <= ST_READ;
                    grp_q   <= '0;
                end
                ST_READ: begin
                    grp_q <= grp_q + 5'd1;
                    if (last_group) begin
                        state_q <= ST_SETTLE;
                    end
                end
                ST_SETTLE: begin
                    // Last index group lands in the bitmap during this cycle
                    state_q    <= ST_WALK;
                    word_sel_o <= '0;
                end
                ST_WALK: begin
                    // Without a credit the word pointer simply holds
                    if (wr_valid_o) begin
                        word_sel_o <= word_sel_o + 6'd1;
                        if (last_word) begin
                            base_ptr_q <= base_ptr_q + poly_hints_i[6:0];
                            poly_idx_o <= poly_idx_o + 4'd1;
                            state_q    <= (poly_idx_o == 4'(HINT_K - 1)) ? ST_DONE : ST_LOAD;
                        end
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/hint_decode_top.sv ====
`timescale 1ns/1ps
// busy_o covers buffered writes; memory content is complete only once busy_o has dropped

module hint_decode_top (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  logic                            start_i,
    input  hint_pkg::hint_sig_t             encoded_h_i,
    input  logic [hint_pkg::MEM_ADDR_W-1:0] base_addr_i,
    input  logic                            mem_stall_i,
    input  logic [hint_pkg::MEM_ADDR_W-1:0] rd_addr_i,
    output hint_pkg::hint_word_t            rd_data_o,
    output logic                            done_o,
    output logic                            busy_o,
    output logic                            error_o
);
    import hint_pkg::*;

    logic     dec_wr_valid;
    hint_wr_t dec_wr_req;
    logic     dec_busy;
    logic     credit_ret;
    logic     fifo_rd_valid;
    hint_wr_t fifo_rd_req;
    logic     pop;

    // Producer with its own sequencer and credit counter
    hint_decode u_decode (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .start_i     (start_i),
        .encoded_h_i (encoded_h_i),
        .base_addr_i (base_addr_i),
        .credit_ret_i(credit_ret),
        .wr_valid_o  (dec_wr_valid),
        .wr_req_o    (dec_wr_req),
        .done_o      (done_o),
        .busy_o      (dec_busy),
        .error_o     (error_o)
    );

    // Write buffer between producer and memory
    credit_fifo u_fifo (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .wr_valid_i  (dec_wr_valid),
        .wr_req_i    (dec_wr_req),
        .pop_i       (pop),
        .rd_valid_o  (fifo_rd_valid),
        .rd_req_o    (fifo_rd_req),
        .credit_ret_o(credit_ret)
    );

    // Coefficient memory, stalled from outside
    hint_mem u_mem (
        .clk       (clk),
        .rd_valid_i(fifo_rd_valid),
        .rd_req_i  (fifo_rd_req),
        .stall_i   (mem_stall_i),
        .rd_addr_i (rd_addr_i),
        .pop_o     (pop),
        .rd_data_o (rd_data_o)
    );

    // Producer busy runs through the done cycle, so the buffer takes over without a gap
    assign busy_o = dec_busy || fifo_rd_valid;

endmodule

// ==== rtl/hint_mem.sv ====
`timescale 1ns/1ps
// Contents are undefined until written; the read port has no conflict check against writes

module hint_mem (
    input  logic                            clk,
    input  logic                            rd_valid_i,
    input  hint_pkg::hint_wr_t              rd_req_i,
    input  logic                            stall_i,
    input  logic [hint_pkg::MEM_ADDR_W-1:0] rd_addr_i,
    output logic                            pop_o,
    output hint_pkg::hint_word_t            rd_data_o
);
    import hint_pkg::*;

    hint_word_t storage [MEM_DEPTH];

    // Take the buffer head in any cycle the port is not stalled
    assign pop_o = rd_valid_i && !stall_i;

    // ----------------------------------------
    // Write and read ports
    // ----------------------------------------

    // Write lands on the edge that ends the pop cycle
    always_ff @(posedge clk) begin
        if (pop_o) begin
            storage[rd_req_i.addr] <= rd_req_i.data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= storage[rd_addr_i];
    end

endmodule

// ==== rtl/hint_pkg.sv ====
// Sizes fixed for one ML-DSA parameter set (OMEGA 75, K 8); nothing here is meant to be overridden

package hint_pkg;

    // ----------------------------------------
    // ML-DSA hint field sizes
    // ----------------------------------------

    // Maximum number of nonzero hints over all polynomials
    localparam int HINT_OMEGA = 75;
    // Polynomials per hint vector
    localparam int HINT_K = 8;
    // Coefficients per polynomial
    localparam int HINT_N = 256;

    // ----------------------------------------
    // Memory geometry and write buffer
    // ----------------------------------------

    // Stored coefficient width and packing of one memory word
    localparam int COEFF_W = 24;
    localparam int COEFFS_PER_WORD = 4;
    localparam int WORDS_PER_POLY = HINT_N / COEFFS_PER_WORD;
    localparam int MEM_DEPTH = HINT_K * WORDS_PER_POLY;
    localparam int MEM_ADDR_W = 9;

    // Buffer depth doubles as the number of credits the producer starts with
    localparam int WR_FIFO_DEPTH = 4;
    // Wide enough to hold a full credit count of WR_FIFO_DEPTH
    localparam int CREDIT_W = 3;

    // ----------------------------------------
    // Shared types
    // ----------------------------------------

    // Index bytes in [HINT_OMEGA-1:0], cumulative counts in the top HINT_K bytes
    typedef logic [HINT_OMEGA+HINT_K-1:0][7:0] hint_sig_t;

    // Lane 0 holds the lowest coefficient of the word
    typedef logic [COEFFS_PER_WORD-1:0][COEFF_W-1:0] hint_word_t;

    // One memory write as it travels through the buffer
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        hint_word_t            data;
    } hint_wr_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for the fail message
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hint_decode -f list.f -o sim_hint_decode \
    || { echo "Build failed"; exit 1; }

./obj_dir/sim_hint_decode > sim.log 2>&1 || echo "Simulator returned a nonzero status" >> sim.log
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "FAIL: run ended without a verdict"; exit 1; }
echo "PASS"

// ==== testbench/hint_decode_chk.sv ====
`timescale 1ns/1ps
// Bound into hint_decode; mirrors the credit count at the buffer link from the write and return strobes

module hint_decode_chk (
    input logic clk,
    input logic reset_n,
    input logic zeroize_i,
    input logic wr_valid_i,
    input logic credit_ret_i,
    input logic done_i
);
    import hint_pkg::*;

    logic [CREDIT_W-1:0] credit_q;

    // Credit count as the buffer sees it, cleared the same way
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_q <= CREDIT_W'(WR_FIFO_DEPTH);
        end else if (zeroize_i) begin
            credit_q <= CREDIT_W'(WR_FIFO_DEPTH);
        end else begin
            credit_q <= credit_q - CREDIT_W'(wr_valid_i) + CREDIT_W'(credit_ret_i);
        end
    end

    // A wrap below zero shows up as a count above the buffer depth
    credit_range_a: assert property (@(posedge clk) disable iff (!reset_n)
        credit_q <= CREDIT_W'(WR_FIFO_DEPTH))
        else $error("credit count left its range");

    // A write may only go out on a held or a returning credit
    wr_credit_a: assert property (@(posedge clk) disable iff (!reset_n)
        wr_valid_i |-> ((credit_q != '0) || credit_ret_i))
        else $error("write issued without a credit");

    done_pulse_a: assert property (@(posedge clk) disable iff (!reset_n)
        done_i |=> !done_i)
        else $error("done pulse longer than one cycle");

endmodule

bind hint_decode hint_decode_chk u_chk (
    .clk         (clk),
    .reset_n     (reset_n),
    .zeroize_i   (zeroize_i),
    .wr_valid_i  (wr_valid_o),
    .credit_ret_i(credit_ret_i),
    .done_i      (done_o)
);

// ==== testbench/tb_hint_decode.sv ====
`timescale 1ns/1ps
// Needs a simulator with timing support; every run is read back in full only when the field is valid

module tb_hint_decode;
    import hint_pkg::*;

    localparam int DONE_TIMEOUT = 20000;
    localparam int IDLE_TIMEOUT = 2000;

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  zeroize_i;
    logic                  start_i;
    hint_sig_t             encoded_h_i;
    logic [MEM_ADDR_W-1:0] base_addr_i;
    logic                  mem_stall_i = 1'b0;
    logic [MEM_ADDR_W-1:0] rd_addr_i;
    hint_word_t            rd_data_o;
    logic                  done_o;
    logic                  busy_o;
    logic                  error_o;

    int                    errors = 0;
    logic                  timed_out = 1'b0;
    logic [31:0]           main_rng = 32'd60114;
    logic [31:0]           stall_rng = 32'd60114;
    logic                  stall_mode = 1'b0;
    int                    stall_left = 0;
    logic                  rd_pending = 1'b0;
    logic                  cmp_valid = 1'b0;
    logic [MEM_ADDR_W-1:0] cmp_addr = '0;
    hint_sig_t             exp_sig = '0;
    logic [MEM_ADDR_W-1:0] exp_base = '0;
    hint_sig_t             field;

    hint_decode_top dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .start_i    (start_i),
        .encoded_h_i(encoded_h_i),
        .base_addr_i(base_addr_i),
        .mem_stall_i(mem_stall_i),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o),
        .done_o     (done_o),
        .busy_o     (busy_o),
        .error_o    (error_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // ----------------------------------------
    // Reference model and checks
    // ----------------------------------------

    // Coefficient c of polynomial j is set when c is among the indices of j
    function automatic hint_word_t expected_word(input hint_sig_t f,
                                                 input logic [MEM_ADDR_W-1:0] base,
                                                 input logic [MEM_ADDR_W-1:0] addr);
        hint_word_t            w;
        logic [MEM_ADDR_W-1:0] offs;
        int                    poly;
        int                    first;
        int                    last;
        int                    c;
        w     = '0;
        offs  = addr - base;
        poly  = int'(offs) / WORDS_PER_POLY;
        first = (poly == 0) ? 0 : int'(f[HINT_OMEGA + poly - 1]);
        last  = int'(f[HINT_OMEGA + poly]);
        for (int l = 0; l < COEFFS_PER_WORD; l++) begin
            c = (int'(offs) % WORDS_PER_POLY) * COEFFS_PER_WORD + l;
            for (int i = first; i < last; i++) begin
                if (int'(f[i]) == c) begin
                    w[l] = COEFF_W'(1);
                end
            end
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    // Random counts per polynomial with sorted distinct indices, never above OMEGA in total
    task automatic make_valid_field(output hint_sig_t f);
        logic [HINT_N-1:0] used;
        int                total;
        int                lim;
        int                cnt;
        int                pick;
        f     = '0;
        total = 0;
        for (int j = 0; j < HINT_K; j++) begin
            used     = '0;
            main_rng = xorshift32(main_rng);
            lim      = (HINT_OMEGA - total < 19) ? HINT_OMEGA - total : 19;
            cnt      = int'(main_rng[15:0]) % (lim + 1);
            for (int h = 0; h < cnt; h++) begin
                main_rng = xorshift32(main_rng);
                pick     = int'(main_rng[7:0]);
                while (used[pick]) begin
                    main_rng = xorshift32(main_rng);
                    pick     = int'(main_rng[7:0]);
                end
                used[pick] = 1'b1;
            end
            for (int c = 0; c < HINT_N; c++) begin
                if (used[c]) begin
                    f[total] = 8'(c);
                    total++;
                end
            end
            f[HINT_OMEGA + j] = 8'(total);
        end
    endtask

    task automatic launch(input hint_sig_t f, input logic [MEM_ADDR_W-1:0] base);
        @(posedge clk);
        encoded_h_i <= f;
        base_addr_i <= base;
        start_i     <= 1'b1;
        @(posedge clk);
        start_i     <= 1'b0;
    endtask

    // Returns error_o as seen in the done cycle
    task automatic wait_done(output logic err);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        err    = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            if (done_o) begin
                seen = 1'b1;
                err  = error_o;
            end
            cycles++;
        end
        if (!seen) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: no done pulse within %0d cycles", DONE_TIMEOUT);
        end
    endtask

    task automatic wait_idle(input logic forbid_done);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy_o && cycles < IDLE_TIMEOUT) begin
            if (forbid_done && done_o) begin
                errors++;
                $display("A done pulse appeared after zeroize");
            end
            @(negedge clk);
            cycles++;
        end
        if (busy_o) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: busy stayed high for %0d cycles", IDLE_TIMEOUT);
        end
    endtask

    task automatic read_back();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            @(posedge clk);
            rd_addr_i  <= MEM_ADDR_W'(a);
            rd_pending <= 1'b1;
        end
        @(posedge clk);
        rd_pending <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // After a timeout the remaining runs are skipped and the run ends at once
    task automatic valid_run(input hint_sig_t f, input logic [MEM_ADDR_W-1:0] base);
        logic err;
        if (!timed_out) begin
            launch(f, base);
            wait_done(err);
        end
        if (!timed_out) begin
            wait_idle(1'b0);
        end
        if (!timed_out) begin
            check_value("error_o", 96'(err), 96'(0));
            exp_sig  = f;
            exp_base = base;
            read_back();
        end
    endtask

    task automatic fault_run(input hint_sig_t f);
        logic err;
        if (!timed_out) begin
            launch(f, '0);
            wait_done(err);
        end
        if (!timed_out) begin
            wait_idle(1'b0);
        end
        if (!timed_out) begin
            check_value("error_o", 96'(err), 96'(1));
        end
    endtask

    // ----------------------------------------
    // Back-pressure and read-back compare
    // ----------------------------------------

    // Short bursts mixed with long stretches at either level
    always @(posedge clk) begin
        if (!stall_mode) begin
            mem_stall_i <= 1'b0;
            stall_left  <= 0;
        end else if (stall_left == 0) begin
            stall_rng = xorshift32(stall_rng);
            mem_stall_i <= stall_rng[0];
            stall_left  <= stall_rng[1] ? 32 + int'(stall_rng[12:8]) : int'(stall_rng[5:4]);
        end else begin
            stall_left <= stall_left - 1;
        end
    end

    // Read data trails its address by one cycle
    always @(posedge clk) begin
        cmp_valid <= rd_pending;
        cmp_addr  <= rd_addr_i;
    end

    always @(negedge clk) begin
        if (cmp_valid) begin
            check_value($sformatf("rd_data_o[%0d]", cmp_addr), rd_data_o,
                        expected_word(exp_sig, exp_base, cmp_addr));
        end
    end

    initial begin
        reset_n     = 1'b0;
        zeroize_i   = 1'b0;
        start_i     = 1'b0;
        encoded_h_i = '0;
        base_addr_i = '0;
        rd_addr_i   = '0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        // Random valid fields at random bases
        for (int r = 0; r < 3; r++) begin
            make_valid_field(field);
            main_rng = xorshift32(main_rng);
            valid_run(field, main_rng[MEM_ADDR_W-1:0]);
        end

        // Same under a stalled memory port
        @(posedge clk);
        stall_mode <= 1'b1;
        for (int r = 0; r < 2; r++) begin
            make_valid_field(field);
            valid_run(field, 9'(r * 37));
        end
        @(posedge clk);
        stall_mode <= 1'b0;

        // One fault per field
        // The second count steps back while its first index group still reads in order
        field = '0;
        field[6:0] = {8'd70, 8'd60, 8'd50, 8'd40, 8'd30, 8'd20, 8'd10};
        field[HINT_OMEGA+HINT_K-1:HINT_OMEGA] = {{6{8'd7}}, 8'd2, 8'd3};
        fault_run(field);
        field = '0;
        field[HINT_OMEGA+HINT_K-1] = 8'd80;
        fault_run(field);
        field = '0;
        field[1:0] = {8'd7, 8'd7};
        field[HINT_OMEGA+HINT_K-1:HINT_OMEGA] = {HINT_K{8'd2}};
        fault_run(field);
        field = '0;
        field[2:0] = {8'd3, 8'd2, 8'd1};
        field[40] = 8'h33;
        field[HINT_OMEGA+HINT_K-1:HINT_OMEGA] = {HINT_K{8'd3}};
        fault_run(field);

        // Edge fields: empty, all hints in one polynomial, index 0 first
        valid_run('0, 9'd0);
        field = '0;
        for (int i = 0; i < HINT_OMEGA; i++) begin
            field[i] = 8'(3 * i + 2);
        end
        field[HINT_OMEGA+HINT_K-1:HINT_OMEGA] = {{3{8'd75}}, {5{8'd0}}};
        valid_run(field, 9'd100);
        field = '0;
        field[4:0] = {8'd1, 8'd0, 8'd255, 8'd9, 8'd0};
        field[HINT_OMEGA+HINT_K-1:HINT_OMEGA] = {{7{8'd5}}, 8'd3};
        valid_run(field, 9'd0);

        // Zeroize partway through a run, then a clean run
        if (!timed_out) begin
            make_valid_field(field);
            launch(field, 9'd0);
            repeat (150) @(posedge clk);
            zeroize_i <= 1'b1;
            @(posedge clk);
            zeroize_i <= 1'b0;
            wait_idle(1'b1);
        end
        make_valid_field(field);
        valid_run(field, 9'd200);

        finish_run();
    end

endmodule
